/* files.f */
mla_dma_pkg.sv
mla_dma_csr_pkg.sv
mla_dma_cfg_if.sv
mla_dma_addr_gen.sv
mla_dma_csr.sv
mla_dma_controller.sv
mla_scratchpad.sv
mla_dma_top.sv
tb_mla_dma.sv

/* mla_dma_addr_gen.sv */
// Strided address generator
// Counts accepted addresses and produces base + (count << stride),
// with first, last and done flags against the programmed length
`timescale 1ns/1ps
`default_nettype none

module mla_dma_addr_gen #(
  parameter int addr_width_p   = mla_dma_pkg::DEFAULT_ADDR_WIDTH,
  parameter int stride_width_p = mla_dma_pkg::DEFAULT_STRIDE_WIDTH,
  parameter int length_width_p = mla_dma_pkg::DEFAULT_LENGTH_WIDTH
) (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,
  input  wire logic                      en_i,
  input  wire logic                      clear_i,
  output logic                           first_o,
  output logic                           last_o,
  output logic                           done_o,
  input  wire logic [addr_width_p-1:0]   base_addr_r_i,
  input  wire logic [stride_width_p-1:0] stride_r_i,
  input  wire logic [length_width_p-1:0] length_r_i,
  output logic      [addr_width_p-1:0]   addr_o,
  output logic                           v_o,
  input  wire logic                      yumi_i
);

  logic [length_width_p-1:0] counter_r;
  logic [length_width_p-1:0] counter_n;

  assign counter_n = counter_r + 1'b1;

  // Clear restarts the sequence, each accept moves to the next element
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      counter_r <= '0;
    end else if (yumi_i) begin
      counter_r <= counter_n;
    end
  end

  assign first_o = (counter_r == '0);
  assign last_o  = (counter_n == length_r_i);
  // Done holds once every element has been accepted
  assign done_o  = (counter_r == length_r_i);

  assign addr_o = base_addr_r_i + (addr_width_p'(counter_r) << stride_r_i);
  assign v_o    = en_i && !done_o;

  // The consumer may only accept an address that is being offered
  yumi_needs_valid_a : assert property (
    @(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o
  );

endmodule

`default_nettype wire

/* mla_dma_cfg_if.sv */
// DMA configuration link
// Carries programmed settings and start from the register block to the
// controller, and state and done back the other way
`timescale 1ns/1ps
`default_nettype none

interface mla_dma_cfg_if #(
  parameter int addr_width_p   = mla_dma_pkg::DEFAULT_ADDR_WIDTH,
  parameter int stride_width_p = mla_dma_pkg::DEFAULT_STRIDE_WIDTH,
  parameter int length_width_p = mla_dma_pkg::DEFAULT_LENGTH_WIDTH
);

  // Transfer settings, stable while a transfer runs
  logic [addr_width_p-1:0]   src_base;
  logic [stride_width_p-1:0] src_stride;
  logic [addr_width_p-1:0]   dst_base;
  logic [stride_width_p-1:0] dst_stride;
  logic [length_width_p-1:0] length;
  // One-cycle launch request
  logic                      start;

  // Controller status, done is a one-cycle pulse at the end of a transfer
  mla_dma_pkg::dma_state_e   state;
  logic                      done;

  modport csr (
    output src_base, src_stride, dst_base, dst_stride, length, start,
    input  state, done
  );

  modport ctrl (
    input  src_base, src_stride, dst_base, dst_stride, length, start,
    output state, done
  );

endinterface

`default_nettype wire

/* mla_dma_controller.sv */
// DMA transfer controller
// Pairs a read address generator on the memory port with a write address
// generator on the scratchpad and steps through IDLE, RUN and DRAIN
`timescale 1ns/1ps
`default_nettype none

module mla_dma_controller #(
  parameter int addr_width_p   = mla_dma_pkg::DEFAULT_ADDR_WIDTH,
  parameter int stride_width_p = mla_dma_pkg::DEFAULT_STRIDE_WIDTH,
  parameter int length_width_p = mla_dma_pkg::DEFAULT_LENGTH_WIDTH,
  parameter int data_width_p   = mla_dma_pkg::DEFAULT_DATA_WIDTH
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  mla_dma_cfg_if.ctrl                  cfg,
  output logic                         mem_v_o,
  output logic      [addr_width_p-1:0] mem_addr_o,
  input  wire logic                    mem_yumi_i,
  input  wire logic                    mem_resp_v_i,
  input  wire logic [data_width_p-1:0] mem_resp_data_i,
  output logic                         spad_w_o,
  output logic      [addr_width_p-1:0] spad_waddr_o,
  output logic      [data_width_p-1:0] spad_wdata_o
);

  mla_dma_pkg::dma_state_e state_r;
  mla_dma_pkg::dma_state_e state_n;
  logic                    launch;
  logic                    rd_done;
  logic                    wr_done;
  logic                    wr_v;

  // A start outside IDLE is dropped
  assign launch = cfg.start && (state_r == mla_dma_pkg::IDLE);

  // Read side issues one request per accept and stops at the length
  mla_dma_addr_gen #(
    .addr_width_p  (addr_width_p),
    .stride_width_p(stride_width_p),
    .length_width_p(length_width_p)
  ) rd_gen (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .en_i         (state_r == mla_dma_pkg::RUN),
    .clear_i      (launch),
    .first_o      (),
    .last_o       (),
    .done_o       (rd_done),
    .base_addr_r_i(cfg.src_base),
    .stride_r_i   (cfg.src_stride),
    .length_r_i   (cfg.length),
    .addr_o       (mem_addr_o),
    .v_o          (mem_v_o),
    .yumi_i       (mem_yumi_i)
  );

  // Write side steps once per in-order response, so its count trails the reads
  mla_dma_addr_gen #(
    .addr_width_p  (addr_width_p),
    .stride_width_p(stride_width_p),
    .length_width_p(length_width_p)
  ) wr_gen (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .en_i         (state_r != mla_dma_pkg::IDLE),
    .clear_i      (launch),
    .first_o      (),
    .last_o       (),
    .done_o       (wr_done),
    .base_addr_r_i(cfg.dst_base),
    .stride_r_i   (cfg.dst_stride),
    .length_r_i   (cfg.length),
    .addr_o       (spad_waddr_o),
    .v_o          (wr_v),
    .yumi_i       (mem_resp_v_i)
  );

  // Each response is written in the cycle it arrives
  assign spad_w_o     = mem_resp_v_i && wr_v;
  assign spad_wdata_o = mem_resp_data_i;

  // The transfer ends once the last response has been written
  always_comb begin
    state_n = state_r;
    case (state_r)
      mla_dma_pkg::IDLE: if (launch) state_n = mla_dma_pkg::RUN;
      mla_dma_pkg::RUN: begin
        if (wr_done) begin
          state_n = mla_dma_pkg::IDLE;
        end else if (rd_done) begin
          state_n = mla_dma_pkg::DRAIN;
        end
      end
      mla_dma_pkg::DRAIN: if (wr_done) state_n = mla_dma_pkg::IDLE;
      default: state_n = mla_dma_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= mla_dma_pkg::IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  assign cfg.state = state_r;
  // Lasts one cycle since the state leaves RUN or DRAIN on the next edge
  assign cfg.done  = (state_r != mla_dma_pkg::IDLE) && wr_done;

  // The memory may only answer requests issued during a transfer
  no_resp_in_idle_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
      (state_r == mla_dma_pkg::IDLE) |-> !mem_resp_v_i
  );

endmodule

`default_nettype wire

/* mla_dma_csr.sv */
// DMA register block
// Holds the host-programmed transfer settings, turns a control write into a
// start pulse and reports controller state and a sticky done flag
`timescale 1ns/1ps
`default_nettype none

module mla_dma_csr #(
  parameter int addr_width_p   = mla_dma_pkg::DEFAULT_ADDR_WIDTH,
  parameter int stride_width_p = mla_dma_pkg::DEFAULT_STRIDE_WIDTH,
  parameter int length_width_p = mla_dma_pkg::DEFAULT_LENGTH_WIDTH,
  parameter int data_width_p   = mla_dma_pkg::DEFAULT_DATA_WIDTH
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    host_w_i,
  input  mla_dma_csr_pkg::csr_addr_e   host_addr_i,
  input  wire logic [data_width_p-1:0] host_wdata_i,
  output logic      [data_width_p-1:0] host_rdata_o,
  mla_dma_cfg_if.csr                   cfg
);

  logic [addr_width_p-1:0]   src_base_r;
  logic [stride_width_p-1:0] src_stride_r;
  logic [addr_width_p-1:0]   dst_base_r;
  logic [stride_width_p-1:0] dst_stride_r;
  logic [length_width_p-1:0] length_r;
  logic                      start_r;
  logic                      done_sticky_r;

  // Settings registers, each host write lands on the next edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_base_r   <= '0;
      src_stride_r <= '0;
      dst_base_r   <= '0;
      dst_stride_r <= '0;
      length_r     <= '0;
    end else if (host_w_i) begin
      case (host_addr_i)
        mla_dma_csr_pkg::SRC_BASE:   src_base_r   <= addr_width_p'(host_wdata_i);
        mla_dma_csr_pkg::SRC_STRIDE: src_stride_r <= stride_width_p'(host_wdata_i);
        mla_dma_csr_pkg::DST_BASE:   dst_base_r   <= addr_width_p'(host_wdata_i);
        mla_dma_csr_pkg::DST_STRIDE: dst_stride_r <= stride_width_p'(host_wdata_i);
        mla_dma_csr_pkg::LENGTH:     length_r     <= length_width_p'(host_wdata_i);
        default: ;
      endcase
    end
  end

  // Start is registered so it appears for exactly the cycle after the write
  // Done-sticky is set by the done pulse and cleared by a start the controller accepts
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      start_r       <= 1'b0;
      done_sticky_r <= 1'b0;
    end else begin
      start_r <= host_w_i && (host_addr_i == mla_dma_csr_pkg::CTRL_STATUS)
                 && host_wdata_i[mla_dma_csr_pkg::CTRL_START_BIT];
      if (cfg.done) begin
        done_sticky_r <= 1'b1;
      end else if (start_r && (cfg.state == mla_dma_pkg::IDLE)) begin
        done_sticky_r <= 1'b0;
      end
    end
  end

  assign cfg.src_base   = src_base_r;
  assign cfg.src_stride = src_stride_r;
  assign cfg.dst_base   = dst_base_r;
  assign cfg.dst_stride = dst_stride_r;
  assign cfg.length     = length_r;
  assign cfg.start      = start_r;

  // Register readback is purely combinational on the selector
  always_comb begin
    host_rdata_o = '0;
    case (host_addr_i)
      mla_dma_csr_pkg::SRC_BASE:   host_rdata_o = data_width_p'(src_base_r);
      mla_dma_csr_pkg::SRC_STRIDE: host_rdata_o = data_width_p'(src_stride_r);
      mla_dma_csr_pkg::DST_BASE:   host_rdata_o = data_width_p'(dst_base_r);
      mla_dma_csr_pkg::DST_STRIDE: host_rdata_o = data_width_p'(dst_stride_r);
      mla_dma_csr_pkg::LENGTH:     host_rdata_o = data_width_p'(length_r);
      mla_dma_csr_pkg::CTRL_STATUS: begin
        host_rdata_o[mla_dma_csr_pkg::STATUS_STATE_LSB +: 2] = cfg.state;
        host_rdata_o[mla_dma_csr_pkg::STATUS_DONE_BIT]      = done_sticky_r;
      end
      default: host_rdata_o = '0;
    endcase
  end

  // Back-to-back start pulses would mean the pulse logic got stuck
  start_single_cycle_a : assert property (
    @(posedge clk_i) disable iff (reset_i) cfg.start |=> !cfg.start
  );

endmodule

`default_nettype wire

/* mla_dma_csr_pkg.sv */
// DMA register map
// Register selector values and bit positions inside the control and status word
`default_nettype none

package mla_dma_csr_pkg;

  // Host register selector, one entry per programmable setting
  typedef enum logic [2:0] {
    SRC_BASE    = 3'd0,
    SRC_STRIDE  = 3'd1,
    DST_BASE    = 3'd2,
    DST_STRIDE  = 3'd3,
    LENGTH      = 3'd4,
    CTRL_STATUS = 3'd5
  } csr_addr_e;

  // Writing a one here in CTRL_STATUS launches a transfer
  localparam int CTRL_START_BIT = 0;

  // Controller state sits in the low bits of a CTRL_STATUS read
  localparam int STATUS_STATE_LSB = 0;

  // Set by the end of a transfer, cleared by the next accepted start
  localparam int STATUS_DONE_BIT = 4;

endpackage

`default_nettype wire

/* mla_dma_pkg.sv */
// DMA engine shared definitions
// Controller state encoding and default widths for the top-level parameters
`default_nettype none

package mla_dma_pkg;

  // IDLE waits for start, RUN issues reads
  // DRAIN has every read issued and waits for the remaining responses
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } dma_state_e;

  // Word addresses on the external memory port
  localparam int DEFAULT_ADDR_WIDTH = 32;
  // Stride is a shift amount, so five bits cover a 32-bit address
  localparam int DEFAULT_STRIDE_WIDTH = 5;
  // Up to 255 words per transfer
  localparam int DEFAULT_LENGTH_WIDTH = 8;
  localparam int DEFAULT_DATA_WIDTH = 32;

endpackage

`default_nettype wire

/* mla_dma_top.sv */
// DMA engine top level
// Register block, transfer controller and scratchpad behind plain host,
// memory and scratchpad ports
`timescale 1ns/1ps
`default_nettype none

module mla_dma_top #(
  parameter int addr_width_p   = mla_dma_pkg::DEFAULT_ADDR_WIDTH,
  parameter int stride_width_p = mla_dma_pkg::DEFAULT_STRIDE_WIDTH,
  parameter int length_width_p = mla_dma_pkg::DEFAULT_LENGTH_WIDTH,
  parameter int data_width_p   = mla_dma_pkg::DEFAULT_DATA_WIDTH,
  parameter int spad_words_p   = 64
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  // Host register access
  input  wire logic                    host_w_i,
  input  mla_dma_csr_pkg::csr_addr_e   host_addr_i,
  input  wire logic [data_width_p-1:0] host_wdata_i,
  output logic      [data_width_p-1:0] host_rdata_o,
  // External memory read port
  output logic                         mem_v_o,
  output logic      [addr_width_p-1:0] mem_addr_o,
  input  wire logic                    mem_yumi_i,
  input  wire logic                    mem_resp_v_i,
  input  wire logic [data_width_p-1:0] mem_resp_data_i,
  // Host view of the scratchpad
  input  wire logic [addr_width_p-1:0] spad_raddr_i,
  output logic      [data_width_p-1:0] spad_rdata_o
);

  logic                    spad_w;
  logic [addr_width_p-1:0] spad_waddr;
  logic [data_width_p-1:0] spad_wdata;

  mla_dma_cfg_if #(
    .addr_width_p  (addr_width_p),
    .stride_width_p(stride_width_p),
    .length_width_p(length_width_p)
  ) cfg ();

  mla_dma_csr #(
    .addr_width_p  (addr_width_p),
    .stride_width_p(stride_width_p),
    .length_width_p(length_width_p),
    .data_width_p  (data_width_p)
  ) csr (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .host_w_i    (host_w_i),
    .host_addr_i (host_addr_i),
    .host_wdata_i(host_wdata_i),
    .host_rdata_o(host_rdata_o),
    .cfg         (cfg.csr)
  );

  mla_dma_controller #(
    .addr_width_p  (addr_width_p),
    .stride_width_p(stride_width_p),
    .length_width_p(length_width_p),
    .data_width_p  (data_width_p)
  ) ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cfg            (cfg.ctrl),
    .mem_v_o        (mem_v_o),
    .mem_addr_o     (mem_addr_o),
    .mem_yumi_i     (mem_yumi_i),
    .mem_resp_v_i   (mem_resp_v_i),
    .mem_resp_data_i(mem_resp_data_i),
    .spad_w_o       (spad_w),
    .spad_waddr_o   (spad_waddr),
    .spad_wdata_o   (spad_wdata)
  );

  mla_scratchpad #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p),
    .spad_words_p(spad_words_p)
  ) spad (
    .clk_i  (clk_i),
    .w_i    (spad_w),
    .waddr_i(spad_waddr),
    .wdata_i(spad_wdata),
    .raddr_i(spad_raddr_i),
    .rdata_o(spad_rdata_o)
  );

endmodule

`default_nettype wire

/* mla_scratchpad.sv */
// Local scratchpad memory
// One write port for the DMA engine and one registered read port for the host
`timescale 1ns/1ps
`default_nettype none

module mla_scratchpad #(
  parameter int addr_width_p = mla_dma_pkg::DEFAULT_ADDR_WIDTH,
  parameter int data_width_p = mla_dma_pkg::DEFAULT_DATA_WIDTH,
  // Depth in words, a power of two so that dropped address bits wrap cleanly
  parameter int spad_words_p = 64
) (
  input  wire logic                    clk_i,
  input  wire logic                    w_i,
  input  wire logic [addr_width_p-1:0] waddr_i,
  input  wire logic [data_width_p-1:0] wdata_i,
  input  wire logic [addr_width_p-1:0] raddr_i,
  output logic      [data_width_p-1:0] rdata_o
);

  localparam int idx_width_lp = $clog2(spad_words_p);

  logic [data_width_p-1:0] mem_r [spad_words_p];
  logic [idx_width_lp-1:0] widx;
  logic [idx_width_lp-1:0] ridx;

  // Only the low index bits select a word
  assign widx = waddr_i[idx_width_lp-1:0];
  assign ridx = raddr_i[idx_width_lp-1:0];

  // Write and read share the clock, read data follows one cycle after the address
  always_ff @(posedge clk_i) begin
    if (w_i) begin
      mem_r[widx] <= wdata_i;
    end
    rdata_o <= mem_r[ridx];
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the DMA engine testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mla_dma \
  -Mdir obj_dir -o tb_mla_dma -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mla_dma > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
  exit 1
fi
if ! grep -q "NO ERRORS" "$log"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

/* tb_mla_dma.sv */
// Testbench for the DMA engine top level
// Models an external memory with random accepts and 1 to 4 cycle response
// latency, then checks request addresses and scratchpad contents per test
`timescale 1ns/1ps
`default_nettype none

module tb_mla_dma;

  localparam int addr_width_lp = 32;
  localparam int data_width_lp = 32;
  localparam int spad_words_lp = 64;
  // Every memory word holds its own address XOR this key
  localparam logic [31:0] mem_key_lp = 32'h5a3c_96e1;
  localparam int total_words_lp = 8 + 8 + 8 + 12 + 8;
  // Reset, then per test the register writes, polling and a full scratchpad scan,
  // plus a wide allowance for each word moved under random stalls
  localparam int timeout_cycles_lp = 16 + 5 * (2 * spad_words_lp + 60) + 16 * total_words_lp;

  logic                       clk;
  logic                       reset;
  logic                       host_w;
  mla_dma_csr_pkg::csr_addr_e host_addr;
  logic [data_width_lp-1:0]   host_wdata;
  logic [data_width_lp-1:0]   host_rdata;
  logic                       mem_v;
  logic [addr_width_lp-1:0]   mem_addr;
  logic                       mem_yumi;
  logic                       mem_resp_v;
  logic [data_width_lp-1:0]   mem_resp_data;
  logic [addr_width_lp-1:0]   spad_raddr;
  logic [data_width_lp-1:0]   spad_rdata;

  integer seed = 32'hb1d2_e8d6;
  int     cycle_count = 0;
  int     err_count = 0;
  int     tests_run = 0;
  bit     stall_en = 1'b0;

  // Requests waiting for their response, and every request of the current transfer
  logic [addr_width_lp-1:0] pend_addr [$];
  int                       pend_due [$];
  logic [addr_width_lp-1:0] req_log [$];

  // Expected scratchpad contents, only entries marked known are compared
  logic [data_width_lp-1:0] expect_spad [spad_words_lp];
  bit                       known [spad_words_lp];

  logic [addr_width_lp-1:0] cur_src_base;
  logic [addr_width_lp-1:0] cur_dst_base;
  int                       cur_src_stride;
  int                       cur_dst_stride;
  int                       cur_length;

  mla_dma_top #(
    .addr_width_p(addr_width_lp),
    .data_width_p(data_width_lp),
    .spad_words_p(spad_words_lp)
  ) uut (
    .clk_i          (clk),
    .reset_i        (reset),
    .host_w_i       (host_w),
    .host_addr_i    (host_addr),
    .host_wdata_i   (host_wdata),
    .host_rdata_o   (host_rdata),
    .mem_v_o        (mem_v),
    .mem_addr_o     (mem_addr),
    .mem_yumi_i     (mem_yumi),
    .mem_resp_v_i   (mem_resp_v),
    .mem_resp_data_i(mem_resp_data),
    .spad_raddr_i   (spad_raddr),
    .spad_rdata_o   (spad_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Ends a run that has stopped making progress
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles_lp) begin
      $display("timeout after %0d cycles, a transfer never reported done", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ mem_key_lp;
  endfunction

  // External memory, driven on the falling edge so the DUT sees stable inputs
  always @(negedge clk) begin : mem_model
    int r;
    r = $random(seed);
    if (reset) begin
      mem_yumi = 1'b0;
      mem_resp_v = 1'b0;
    end else begin
      // The oldest pending request answers once its latency has run out
      if (pend_due.size() > 0 && pend_due[0] <= cycle_count) begin
        mem_resp_v = 1'b1;
        mem_resp_data = mem_word(pend_addr[0]);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end else begin
        mem_resp_v = 1'b0;
      end
      // Only an offered request is taken, and only on some cycles when stalling
      if (mem_v && (!stall_en || r[0])) begin
        mem_yumi = 1'b1;
        pend_addr.push_back(mem_addr);
        pend_due.push_back(cycle_count + 1 + int'(r[2:1]));
        req_log.push_back(mem_addr);
      end else begin
        mem_yumi = 1'b0;
      end
    end
  end

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
    err_count++;
  endtask

  task automatic report_failure(input string name, input string msg);
    $display("FAILURE %s %s", name, msg);
    err_count++;
  endtask

  task automatic write_reg(input mla_dma_csr_pkg::csr_addr_e addr,
                           input logic [data_width_lp-1:0] data);
    @(negedge clk);
    host_w = 1'b1;
    host_addr = addr;
    host_wdata = data;
    @(negedge clk);
    host_w = 1'b0;
  endtask

  task automatic read_status(output logic [data_width_lp-1:0] status);
    @(negedge clk);
    host_addr = mla_dma_csr_pkg::CTRL_STATUS;
    @(negedge clk);
    status = host_rdata;
  endtask

  // Read data is registered, so it is taken one cycle after the address
  task automatic read_spad(input logic [addr_width_lp-1:0] addr,
                           output logic [data_width_lp-1:0] data);
    @(negedge clk);
    spad_raddr = addr;
    @(negedge clk);
    data = spad_rdata;
  endtask

  task automatic start_transfer(input logic [31:0] src_base, input int src_stride,
                                input logic [31:0] dst_base, input int dst_stride,
                                input int length);
    cur_src_base = src_base;
    cur_src_stride = src_stride;
    cur_dst_base = dst_base;
    cur_dst_stride = dst_stride;
    cur_length = length;
    req_log.delete();
    write_reg(mla_dma_csr_pkg::SRC_BASE, src_base);
    write_reg(mla_dma_csr_pkg::SRC_STRIDE, data_width_lp'(src_stride));
    write_reg(mla_dma_csr_pkg::DST_BASE, dst_base);
    write_reg(mla_dma_csr_pkg::DST_STRIDE, data_width_lp'(dst_stride));
    write_reg(mla_dma_csr_pkg::LENGTH, data_width_lp'(length));
    write_reg(mla_dma_csr_pkg::CTRL_STATUS, 32'd1 << mla_dma_csr_pkg::CTRL_START_BIT);
  endtask

  // The sticky bit is cleared one cycle after the start write lands
  task automatic wait_done(output int waited);
    waited = 0;
    host_addr = mla_dma_csr_pkg::CTRL_STATUS;
    @(negedge clk);
    while (!host_rdata[mla_dma_csr_pkg::STATUS_DONE_BIT]) begin
      @(negedge clk);
      waited++;
    end
  endtask

  // Compares the issued reads with base plus i times two to the stride
  // and notes where each word lands
  task automatic record_copy(input string name);
    logic [addr_width_lp-1:0] exp_addr;
    logic [addr_width_lp-1:0] dst;
    int                       idx;
    if (req_log.size() != cur_length) begin
      report_failure(name, $sformatf("saw %0d memory requests for a length of %0d",
                                     req_log.size(), cur_length));
    end
    for (int i = 0; i < cur_length; i++) begin
      exp_addr = cur_src_base + addr_width_lp'(i * (1 << cur_src_stride));
      if (i < req_log.size() && req_log[i] !== exp_addr) begin
        report_mismatch(name, $sformatf("request %0d address", i), exp_addr, req_log[i]);
      end
      dst = cur_dst_base + addr_width_lp'(i * (1 << cur_dst_stride));
      idx = int'(dst % spad_words_lp);
      expect_spad[idx] = mem_word(exp_addr);
      known[idx] = 1'b1;
    end
  endtask

  task automatic run_copy(input string name, input logic [31:0] src_base, input int src_stride,
                          input logic [31:0] dst_base, input int dst_stride, input int length);
    int waited;
    start_transfer(src_base, src_stride, dst_base, dst_stride, length);
    wait_done(waited);
    record_copy(name);
  endtask

  // Scans every entry written so far, which also covers entries a later test skipped
  task automatic check_spad(input string name);
    logic [data_width_lp-1:0] data;
    for (int idx = 0; idx < spad_words_lp; idx++) begin
      if (known[idx]) begin
        read_spad(addr_width_lp'(idx), data);
        if (data !== expect_spad[idx]) begin
          report_mismatch(name, $sformatf("spad[%0d]", idx), expect_spad[idx], data);
        end
      end
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d bad checks", name, err_count - errs_before);
    end
  endtask

  task automatic test_contiguous();
    int errs_before;
    errs_before = err_count;
    run_copy("contiguous_copy", 32'h0000_0100, 0, 32'd16, 0, 8);
    check_spad("contiguous_copy");
    end_test("contiguous_copy", errs_before);
  endtask

  task automatic test_strided_src();
    int errs_before;
    errs_before = err_count;
    run_copy("strided_source", 32'h0000_0200, 2, 32'd24, 0, 8);
    check_spad("strided_source");
    end_test("strided_source", errs_before);
  endtask

  // Even entries 16 to 30 are rewritten, odd ones keep the data of the two tests before
  task automatic test_strided_dst();
    int errs_before;
    errs_before = err_count;
    run_copy("strided_destination", 32'h0000_0280, 0, 32'd16, 1, 8);
    check_spad("strided_destination");
    end_test("strided_destination", errs_before);
  endtask

  task automatic test_back_pressure();
    int errs_before;
    errs_before = err_count;
    stall_en = 1'b1;
    run_copy("back_pressure", 32'h0000_0300, 0, 32'd32, 0, 12);
    stall_en = 1'b0;
    for (int i = 0; i < req_log.size(); i++) begin
      for (int j = i + 1; j < req_log.size(); j++) begin
        if (req_log[i] == req_log[j]) begin
          report_failure("back_pressure", $sformatf("address %h was requested twice",
                                                    req_log[i]));
        end
      end
    end
    check_spad("back_pressure");
    end_test("back_pressure", errs_before);
  endtask

  task automatic test_zero_length_status();
    int                       errs_before;
    int                       waited;
    logic [data_width_lp-1:0] status;
    errs_before = err_count;
    start_transfer(32'h0000_0500, 0, 32'd0, 0, 0);
    wait_done(waited);
    if (req_log.size() != 0) begin
      report_failure("zero_length_status", "a zero-length transfer issued memory requests");
    end
    // The start pulse cycle plus one RUN cycle, so done shows on the second poll
    if (waited != 1) begin
      report_failure("zero_length_status",
                     $sformatf("zero length took %0d cycles instead of 2", waited + 1));
    end
    read_status(status);
    if (status[mla_dma_csr_pkg::STATUS_STATE_LSB +: 2] !== mla_dma_pkg::IDLE) begin
      report_mismatch("zero_length_status", "state after done", mla_dma_pkg::IDLE,
                      status[mla_dma_csr_pkg::STATUS_STATE_LSB +: 2]);
    end
    // A second start while the copy is running must be dropped
    start_transfer(32'h0000_0400, 0, 32'd48, 0, 8);
    read_status(status);
    if (status[mla_dma_csr_pkg::STATUS_STATE_LSB +: 2] !== mla_dma_pkg::RUN) begin
      report_mismatch("zero_length_status", "state after start", mla_dma_pkg::RUN,
                      status[mla_dma_csr_pkg::STATUS_STATE_LSB +: 2]);
    end
    write_reg(mla_dma_csr_pkg::CTRL_STATUS, 32'd1 << mla_dma_csr_pkg::CTRL_START_BIT);
    wait_done(waited);
    record_copy("zero_length_status");
    repeat (10) @(negedge clk);
    if (req_log.size() != 8) begin
      report_failure("zero_length_status", "a start during a transfer launched another one");
    end
    read_status(status);
    if (status[mla_dma_csr_pkg::STATUS_STATE_LSB +: 2] !== mla_dma_pkg::IDLE) begin
      report_mismatch("zero_length_status", "final state", mla_dma_pkg::IDLE,
                      status[mla_dma_csr_pkg::STATUS_STATE_LSB +: 2]);
    end
    check_spad("zero_length_status");
    end_test("zero_length_status", errs_before);
  endtask

  initial begin
    reset = 1'b1;
    host_w = 1'b0;
    host_addr = mla_dma_csr_pkg::SRC_BASE;
    host_wdata = '0;
    mem_yumi = 1'b0;
    mem_resp_v = 1'b0;
    mem_resp_data = '0;
    spad_raddr = '0;
    for (int i = 0; i < spad_words_lp; i++) begin
      known[i] = 1'b0;
      expect_spad[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_contiguous();
    test_strided_src();
    test_strided_dst();
    test_back_pressure();
    test_zero_length_status();

    $display("tests run %0d, failed checks %0d", tests_run, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
